// File: rtl/n163_pkg.sv
// n163_pkg: page constants, cpu bus struct, control byte union, prg/chr map structs
package n163_pkg;

	// page selectors, compared against addr[15:11]
	localparam logic [4:0] PAGE_SND    = 5'b01001; // 4800
	localparam logic [4:0] PAGE_IRQ_LO = 5'b01010; // 5000
	localparam logic [4:0] PAGE_IRQ_HI = 5'b01011; // 5800
	localparam logic [4:0] PAGE_PTR    = 5'b11111; // f800
	localparam logic [4:0] CHR_REG_FIRST = 5'b10000;

	localparam logic [7:0] NT_BANK_MIN = 8'hE0;
	localparam int NUM_CH   = 8;
	localparam int RAM_AW   = 7;
	localparam int AUDIO_W  = 11;
	localparam int SLOT_MAX = 14;

	typedef struct packed {
		logic        ce;
		logic        wr;
		logic [15:0] addr;
		logic [7:0]  din;
	} cpu_bus_t;

	typedef struct packed {
		logic [1:0] top;
		logic [5:0] bank;
	} bank_view_t;

	typedef struct packed {
		logic       autoinc;
		logic [6:0] ram_addr;
	} ptr_view_t;

	// same data byte, meaning depends on the page written
	typedef union packed {
		bank_view_t bank_view; // e000, e800, f000
		ptr_view_t  ptr_view;  // f800
	} ctl_byte_u;

	typedef struct packed {
		logic [5:0] prg_bank;
		logic       wram_sel;
	} prg_map_t;

	typedef struct packed {
		logic [7:0] chr_bank;
		logic       chr_ram;
		logic       ciram_ce;
		logic       ciram_a10;
	} chr_map_t;

endpackage

// File: rtl/bank_regs.sv
// bank_regs: chr/prg bank registers, chr ram enables, sound disable, address translation
`timescale 1ns/100ps

module bank_regs import n163_pkg::*; (
	input  logic        clk20,
	input  logic        reset,
	input  cpu_bus_t    bus,
	input  logic [13:0] chr_addr,
	output prg_map_t    prg,
	output chr_map_t    chr,
	output logic        snd_off
);

	logic [7:0] chr_reg [12]; // 0-7 pattern, 8-11 c000-d800
	logic [5:0] prg_89, prg_ab, prg_cd;
	logic [1:0] chr_en;
	logic [4:0] page;
	logic [4:0] chr_idx;
	ctl_byte_u  ctl;
	logic [7:0] sel_bank;
	logic       half_en;

	assign page    = bus.addr[15:11];
	assign chr_idx = page - CHR_REG_FIRST;
	assign ctl     = bus.din;

	always_ff @(posedge clk20) begin
		if (reset) begin
			for (int i = 0; i < 12; i++) begin
				chr_reg[i] <= '0;
			end
			prg_89  <= '0;
			prg_ab  <= '0;
			prg_cd  <= '0;
			chr_en  <= '0;
			snd_off <= 1'b0;
		end else if (bus.ce && bus.wr && page >= CHR_REG_FIRST) begin
			case (page)
				5'b11100: begin // e000
					prg_89  <= ctl.bank_view.bank;
					snd_off <= ctl.bank_view.top[0];
				end
				5'b11101: begin // e800
					prg_ab <= ctl.bank_view.bank;
					chr_en <= ctl.bank_view.top;
				end
				5'b11110: prg_cd <= ctl.bank_view.bank;
				PAGE_PTR: ; // sound pointer lives in wave_ram
				default: chr_reg[chr_idx[3:0]] <= bus.din;
			endcase
		end
	end

	// prg side
	always_comb begin
		case (bus.addr[14:13])
			2'd0:    prg.prg_bank = prg_89;
			2'd1:    prg.prg_bank = prg_ab;
			2'd2:    prg.prg_bank = prg_cd;
			default: prg.prg_bank = 6'h3F; // fixed last bank
		endcase
		if (!bus.addr[15]) begin
			prg.prg_bank = '0;
		end
		prg.wram_sel = bus.addr[15:13] == 3'b011;
	end

	// chr side
	always_comb begin
		if (chr_addr[13]) begin
			sel_bank = chr_reg[{2'b10, chr_addr[11:10]}]; // nametables mirror c-d regs
		end else begin
			sel_bank = chr_reg[{1'b0, chr_addr[12:10]}];
		end
		half_en = (chr_addr[13] | chr_addr[12]) ? chr_en[1] : chr_en[0];
		chr.chr_bank  = sel_bank;
		chr.chr_ram   = sel_bank >= NT_BANK_MIN && !half_en;
		chr.ciram_ce  = chr_addr[13] && chr.chr_ram;
		chr.ciram_a10 = sel_bank[0];
	end

	// upper chr rom enable written, nametables leave ciram
	assert property (@(posedge clk20) disable iff (reset)
		bus.ce && bus.wr && page == 5'b11101 && bus.din[7] |=> !chr.ciram_ce);

endmodule

// File: rtl/irq_counter.sv
// irq_counter: 15-bit up counter with enable bit, irq flag and cpu readback
`timescale 1ns/100ps

module irq_counter import n163_pkg::*; (
	input  logic        clk20,
	input  logic        reset,
	input  cpu_bus_t    bus,
	output logic        irq,
	output logic [15:0] count
);

	logic [4:0]  page;
	logic [15:0] count_next;
	logic        count_up;

	assign page       = bus.addr[15:11];
	assign count_next = count + 16'd1;
	assign count_up   = count[15] && !(&count[14:0]); // stops at 7fff

	always_ff @(posedge clk20) begin
		if (reset) begin
			count <= '0;
			irq   <= 1'b0;
		end else if (bus.ce) begin
			if (page[4:1] == PAGE_IRQ_LO[4:1]) begin
				irq <= 1'b0; // any 5000-5fff access acks
			end else if (count == 16'hFFFF) begin
				irq <= 1'b1;
			end

			if (bus.wr && page == PAGE_IRQ_LO) begin
				count[7:0] <= bus.din;
			end else if (count_up) begin
				count[7:0] <= count_next[7:0];
			end

			if (bus.wr && page == PAGE_IRQ_HI) begin
				count[15:8] <= bus.din;
			end else if (count_up) begin
				count[15:8] <= count_next[15:8];
			end
		end
	end

	assert property (@(posedge clk20) disable iff (reset)
		$rose(irq) |-> $past(count) == 16'hFFFF);

endmodule

// File: rtl/wave_ram.sv
// wave_ram: sound ram pointer with auto-increment, 128x8 dual-port memory
`timescale 1ns/100ps

module wave_ram import n163_pkg::*; (
	input  logic              clk20,
	input  logic              reset,
	input  cpu_bus_t          bus,
	output logic [7:0]        cpu_q,
	input  logic [RAM_AW-1:0] syn_addr,
	output logic [7:0]        syn_data
);

	logic [7:0]        mem [2**RAM_AW];
	logic [RAM_AW-1:0] ptr;
	logic              autoinc;
	logic              do_inc;
	logic [4:0]        page;
	ctl_byte_u         ctl;

	assign page = bus.addr[15:11];
	assign ctl  = bus.din;

	always_ff @(posedge clk20) begin
		if (reset) begin
			ptr     <= '0;
			autoinc <= 1'b0;
			do_inc  <= 1'b0;
		end else begin
			do_inc <= bus.ce && page == PAGE_SND && autoinc;
			if (do_inc) begin
				ptr <= ptr + 1'd1;
			end
			if (bus.ce && bus.wr && page == PAGE_PTR) begin
				ptr     <= ctl.ptr_view.ram_addr;
				autoinc <= ctl.ptr_view.autoinc;
			end
		end
	end

	// port a, cpu side
	always_ff @(posedge clk20) begin
		if (bus.ce && bus.wr && page == PAGE_SND) begin
			mem[ptr] <= bus.din;
		end
		cpu_q <= mem[ptr];
	end

	// port b, synth side, read only
	always_ff @(posedge clk20) begin
		syn_data <= mem[syn_addr];
	end

endmodule

// File: rtl/wave_synth.sv
// wave_synth: slot sequencer, per-channel phase and sample position, output accumulator
`timescale 1ns/100ps

module wave_synth import n163_pkg::*; (
	input  logic               clk20,
	input  logic               reset,
	input  logic               ce,
	input  logic               snd_off,
	output logic [RAM_AW-1:0]  syn_addr,
	input  logic [7:0]         syn_data,
	output logic [AUDIO_W-1:0] audio
);

	logic [3:0]         slot;
	logic [2:0]         step;
	logic [2:0]         ch;
	logic [23:0]        phase [NUM_CH]; // phase accumulator, carry out steps pos
	logic [4:0]         pos [NUM_CH];
	logic               carry;
	logic               nib_hi;
	logic [3:0]         sample;
	logic [AUDIO_W-1:0] acc;
	logic [AUDIO_W-1:0] audio_q;
	logic [8:0]         sum_hi;
	logic [7:0]         sample_addr;
	logic [7:0]         chan_out;
	logic [AUDIO_W-1:0] sum;

	assign sum_hi      = phase[ch][23:16] + {6'd0, syn_data[1:0]} + carry;
	assign sample_addr = syn_data + {3'b000, pos[ch]};
	assign chan_out    = sample * syn_data[3:0];
	assign sum         = acc + AUDIO_W'(chan_out);

	always_ff @(posedge clk20) begin
		if (reset) begin
			slot <= '0;
		end else if (ce) begin
			slot <= (slot == 4'(SLOT_MAX)) ? 4'd0 : slot + 4'd1;
		end
	end

	// ram address per step, data comes back one clock later
	always_comb begin
		case (step)
			3'd0:    syn_addr = {1'b1, ch, 3'd0}; // freq lo
			3'd1:    syn_addr = {1'b1, ch, 3'd2}; // freq mid
			3'd2:    syn_addr = {1'b1, ch, 3'd4}; // length, freq hi
			3'd3:    syn_addr = {1'b1, ch, 3'd6}; // wave address
			3'd4:    syn_addr = sample_addr[7:1];
			default: syn_addr = {1'b1, ch, 3'd7}; // volume
		endcase
	end

	always_ff @(posedge clk20) begin
		if (reset) begin
			step    <= '0;
			ch      <= 3'd7;
			carry   <= 1'b0;
			nib_hi  <= 1'b0;
			sample  <= '0;
			acc     <= '0;
			audio_q <= '0;
			for (int i = 0; i < NUM_CH; i++) begin
				phase[i] <= '0;
				pos[i]   <= '0;
			end
		end else begin
			if (slot[1:0] == 2'd0) begin
				step <= '0;
			end else if (step != 3'd7) begin
				step <= step + 3'd1;
			end
			case (step)
				3'd1: {carry, phase[ch][7:0]} <= phase[ch][7:0] + syn_data;
				3'd2: {carry, phase[ch][15:8]} <= phase[ch][15:8] + syn_data + carry;
				3'd3: begin
					phase[ch][23:16] <= sum_hi[7:0];
					if (sum_hi[8]) begin
						// wrap at programmed length
						pos[ch] <= (pos[ch] == {~syn_data[4:2], 2'b11}) ? 5'd0 : pos[ch] + 5'd1;
					end
				end
				3'd4: nib_hi <= sample_addr[0];
				3'd5: sample <= nib_hi ? syn_data[7:4] : syn_data[3:0];
				3'd6: begin
					if (ch == 3'd7) begin
						ch      <= ~syn_data[6:4]; // channel count from ch7 volume byte
						acc     <= '0;
						audio_q <= sum;
					end else begin
						ch  <= ch + 3'd1;
						acc <= sum;
					end
				end
				default: ;
			endcase
		end
	end

	assign audio = snd_off ? '0 : audio_q;

	// output only moves at the end of a sweep
	assert property (@(posedge clk20) disable iff (reset)
		$changed(audio_q) |-> $past(step) == 3'd6 && $past(ch) == 3'd7);

endmodule

// File: rtl/n163_top.sv
// n163_top: mapper top, register file, irq counter, sound ram, synth, cpu read mux
`timescale 1ns/100ps

module n163_top import n163_pkg::*; (
	input  logic               clk20,
	input  logic               reset,
	input  cpu_bus_t           bus,
	input  logic [13:0]        chr_addr,
	output logic [7:0]         cpu_dout,
	output logic               cpu_oe,
	output prg_map_t           prg,
	output chr_map_t           chr,
	output logic               irq,
	output logic [AUDIO_W-1:0] audio
);

	logic [4:0]        page;
	logic              snd_off;
	logic [15:0]       irq_count;
	logic [7:0]        snd_q;
	logic [RAM_AW-1:0] syn_addr;
	logic [7:0]        syn_data;

	assign page = bus.addr[15:11];

	bank_regs bank_regs_inst (
		.clk20    (clk20),
		.reset    (reset),
		.bus      (bus),
		.chr_addr (chr_addr),
		.prg      (prg),
		.chr      (chr),
		.snd_off  (snd_off)
	);

	irq_counter irq_counter_inst (
		.clk20 (clk20),
		.reset (reset),
		.bus   (bus),
		.irq   (irq),
		.count (irq_count)
	);

	wave_ram wave_ram_inst (
		.clk20    (clk20),
		.reset    (reset),
		.bus      (bus),
		.cpu_q    (snd_q),
		.syn_addr (syn_addr),
		.syn_data (syn_data)
	);

	wave_synth wave_synth_inst (
		.clk20    (clk20),
		.reset    (reset),
		.ce       (bus.ce),
		.snd_off  (snd_off),
		.syn_addr (syn_addr),
		.syn_data (syn_data),
		.audio    (audio)
	);

	always_comb begin
		case (page)
			PAGE_SND:    cpu_dout = snd_q;
			PAGE_IRQ_LO: cpu_dout = irq_count[7:0];
			PAGE_IRQ_HI: cpu_dout = irq_count[15:8];
			default:     cpu_dout = bus.din; // open bus
		endcase
	end

	// mapper regs, work ram at 6000-7fff, rom at 8000+
	assign cpu_oe = !bus.wr && (page == PAGE_SND || page == PAGE_IRQ_LO ||
		page == PAGE_IRQ_HI || bus.addr[15:13] == 3'b011 || bus.addr[15]);

endmodule

// File: test/n163_tb.sv
// n163_tb: clock and reset, vector file reader, cpu bus driver, value checks, timeout
`timescale 1ns/100ps

module n163_tb import n163_pkg::*; ();

	logic               clk20;
	logic               reset;
	cpu_bus_t           bus;
	logic [13:0]        chr_addr;
	logic [7:0]         cpu_dout;
	logic               cpu_oe;
	prg_map_t           prg;
	chr_map_t           chr;
	logic               irq;
	logic [AUDIO_W-1:0] audio;

	byte         vec_op [$];
	logic [15:0] vec_addr [$];
	logic [15:0] vec_data [$];
	logic [19:0] vec_exp [$];
	int          checks;
	int          errors;
	int          cycles;
	int          cycle_limit;
	bit          vectors_ok;

	n163_top n163_top_inst (
		.clk20    (clk20),
		.reset    (reset),
		.bus      (bus),
		.chr_addr (chr_addr),
		.cpu_dout (cpu_dout),
		.cpu_oe   (cpu_oe),
		.prg      (prg),
		.chr      (chr),
		.irq      (irq),
		.audio    (audio)
	);

	initial clk20 = 1'b0;
	always #50 clk20 = ~clk20; // 100 ns period

	always @(posedge clk20) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout, vectors did not finish within %0d cycles", cycle_limit);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, expected);
		end
	endtask

	task automatic read_vectors();
		int          fd;
		int          n;
		int          slots;
		string       line;
		byte         op;
		logic [15:0] a;
		logic [15:0] d;
		logic [19:0] e;
		slots = 0;
		vectors_ok = 1'b0;
		fd = $fopen("test/n163_vectors.txt", "r");
		if (fd != 0) begin
			vectors_ok = 1'b1;
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != "#") begin
					if ($sscanf(line, "%c %h %h %h", op, a, d, e) == 4) begin
						vec_op.push_back(op);
						vec_addr.push_back(a);
						vec_data.push_back(d);
						vec_exp.push_back(e);
						slots += (op == "A") ? int'(d) : 1; // A waits d strobes
					end else begin
						$display("vector line could not be parsed: %s", line);
						vectors_ok = 1'b0;
					end
				end
			end
			$fclose(fd);
			cycle_limit = 10 + 12 * slots + 200;
		end
	endtask

	// one ce strobe, returns at the sample point inside the ce cycle
	task automatic begin_access(input logic wr, input logic [15:0] addr,
		input logic [7:0] din, input logic [13:0] chr_a);
		@(posedge clk20);
		bus      <= {1'b1, wr, addr, din};
		chr_addr <= chr_a;
		@(negedge clk20);
	endtask

	task automatic end_access();
		@(posedge clk20);
		bus.ce <= 1'b0;
		bus.wr <= 1'b0;
		@(negedge clk20); // first stable point after the access
	endtask

	task automatic idle_gap();
		repeat (10) @(posedge clk20); // keeps ce at one in 12 clocks
	endtask

	task automatic run_vector(input byte op, input logic [15:0] a,
		input logic [15:0] d, input logic [19:0] e);
		case (op)
			"W": begin
				begin_access(1'b1, a, d[7:0], 14'h0);
				end_access();
				idle_gap();
			end
			"R": begin
				begin_access(1'b0, a, 8'h00, 14'h0);
				compare_value("cpu_dout", cpu_dout, e);
				compare_value("cpu_oe", cpu_oe, 1);
				end_access();
				idle_gap();
			end
			"M": begin
				begin_access(1'b0, a, 8'h00, d[13:0]);
				compare_value("prg", prg, e[18:12]);
				compare_value("chr", chr, e[10:0]);
				end_access();
				idle_gap();
			end
			"I": begin
				begin_access(1'b0, a, 8'h00, 14'h0);
				end_access();
				compare_value("irq", irq, e);
				idle_gap();
			end
			"A": begin
				repeat (d) begin
					begin_access(1'b0, 16'h0000, 8'h00, 14'h0);
					end_access();
					idle_gap();
				end
				@(negedge clk20);
				compare_value("audio", audio, e);
			end
			default: begin
				errors++;
				$display("unknown vector op %c at address %h", op, a);
			end
		endcase
	endtask

	initial begin
		checks      = 0;
		errors      = 0;
		cycles      = 0;
		cycle_limit = 0;
		reset       = 1'b1;
		bus         = '0;
		chr_addr    = '0;
		read_vectors();
		if (!vectors_ok) begin
			$display("vector file test/n163_vectors.txt is missing or malformed");
			$display("TEST FAIL");
			$finish;
		end else begin
			repeat (10) @(posedge clk20);
			reset <= 1'b0;
			for (int i = 0; i < vec_op.size(); i++) begin
				run_vector(vec_op[i], vec_addr[i], vec_data[i], vec_exp[i]);
			end
			$display("checks %0d, errors %0d", checks, errors);
			if (errors == 0) begin
				$display("TEST PASS");
			end else begin
				$display("TEST FAIL");
			end
			$finish;
		end
	end

endmodule

// File: vlog.f
rtl/n163_pkg.sv
rtl/bank_regs.sv
rtl/irq_counter.sv
rtl/wave_ram.sv
rtl/wave_synth.sv
rtl/n163_top.sv
test/n163_tb.sv

// File: Makefile
TOP = n163_tb

.PHONY: compile run clean

compile:
	verilator --binary -j 0 --assert -Wno-fatal --top-module $(TOP) -f vlog.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/n163_vectors.txt
# op addr data expect, all hex; W write, R read, M map, I irq after access, A audio
# M: data is chr_addr, expect is {prg, 0, chr}; A: data is ce strobes to wait
W 8000 0021 00000
W 8800 0022 00000
W B800 0027 00000
W E000 0005 00000
W E800 000A 00000
W F000 000C 00000
M 8000 0000 0A109
M A000 0400 14110
M C000 1C00 18139
M E000 0000 7E109
M 6000 0000 01109
# nametable banks routed to ciram
W C000 00E0 00000
M 8000 2000 0A706
W C800 00E1 00000
M 8000 2400 0A70F
W E800 008A 00000
M 8000 2000 0A700
# irq counter from fffe
W 5000 00FE 00000
W 5800 00FF 00000
I 0000 0000 00000
I 0000 0000 00001
R 5000 0000 000FF
R 5800 0000 000FF
I 0000 0000 00001
I 5000 0000 00000
W 5800 0000 00000
I 0000 0000 00000
# sound ram pointer with autoinc
W F800 0080 00000
W 4800 00A1 00000
W 4800 00B2 00000
W 4800 00C3 00000
W F800 0080 00000
R 4800 0000 000A1
R 4800 0000 000B2
R 4800 0000 000C3
# channel 7 alone, wave nibble 5
W F800 0080 00000
W 4800 0055 00000
W 4800 0055 00000
W F800 00F8 00000
W 4800 0000 00000
W 4800 0000 00000
W 4800 0000 00000
W 4800 0000 00000
W 4800 0000 00000
W 4800 0000 00000
W 4800 0000 00000
W 4800 0007 00000
A 0000 0040 00023
W E000 0045 00000
A 0000 0002 00000
W E000 0005 00000
A 0000 0002 00023
W F800 00FF 00000
W 4800 000C 00000
A 0000 0040 0003C
